// ==== rtl/eth_tc_map_pkg.sv ====
// host map for two channels only; the region field is always the top two byte-address bits
package eth_tc_map_pkg;

	//////////////////////////////////////////////////////////////////////
	// host address map
	//////////////////////////////////////////////////////////////////////

	localparam int HOST_ADDR_W = 14;
	// region field sits above this bit
	localparam int REGION_LSB  = 12;

	localparam logic [1:0] REGION_1588 = 2'd0;
	localparam logic [1:0] REGION_SEL  = 2'd1;
	localparam logic [1:0] REGION_STD0 = 2'd2;
	localparam logic [1:0] REGION_STD3 = 2'd3;

	// window offset widths
	localparam int OFS_1588_W = 8;
	localparam int OFS_STD_W  = 12;

	localparam int MM_DATA_W  = 32;

	//////////////////////////////////////////////////////////////////////
	// selector register window
	//////////////////////////////////////////////////////////////////////

	localparam logic SEL_CTRL_OFS = 1'b0;
	localparam logic SEL_STAT_OFS = 1'b1;

	// one word, read as control or as per-channel status
	typedef union packed
	{
		struct packed
		{
			logic [MM_DATA_W-2:0] rsvd;
			logic                 sel;
		} ctrl;
		struct packed
		{
			logic [MM_DATA_W-5:0] rsvd;
			logic [1:0]           busy;
			logic [1:0]           eff_sel;
		} stat;
	} sel_word_u;

endpackage

// ==== rtl/eth_tc_stream_pkg.sv ====
// Avalon-ST widths of the MAC side; the channel count is fixed at 2 by the status word layout
package eth_tc_stream_pkg;

	// two MAC channels
	localparam int NUM_CHANNELS = 2;

	// stream payload
	localparam int ST_DATA_W   = 64;
	localparam int ST_EMPTY_W  = 3;
	// receive error carries the MAC error code, transmit error is one bit
	localparam int ST_RX_ERR_W = 6;

	// source select codes, shared by the register and the path muxes
	localparam logic SRC_1588 = 1'b0;
	localparam logic SRC_STD  = 1'b1;

endpackage

// ==== rtl/eth_tc_addr_decoder.sv ====
// purely combinational; an unmapped upper offset bit inside a window is simply ignored
`timescale 1ns/1ps

module eth_tc_addr_decoder
	import eth_tc_map_pkg::*;
(
	// host side
	input  logic                   avl_mm_read,
	input  logic                   avl_mm_write,
	input  logic [HOST_ADDR_W-1:0] avl_mm_baddress,
	input  logic [MM_DATA_W-1:0]   avl_mm_writedata,
	output logic [MM_DATA_W-1:0]   avl_mm_readdata,
	output logic                   avl_mm_waitrequest,

	// 1588 controller window
	output logic                   ptp_mm_read,
	output logic                   ptp_mm_write,
	output logic [OFS_1588_W-1:0]  ptp_mm_address,
	output logic [MM_DATA_W-1:0]   ptp_mm_writedata,
	input  logic [MM_DATA_W-1:0]   ptp_mm_readdata,
	input  logic                   ptp_mm_waitrequest,

	// selector window, never waits
	output logic                   sel_mm_read,
	output logic                   sel_mm_write,
	output logic [0:0]             sel_mm_address,
	output logic [MM_DATA_W-1:0]   sel_mm_writedata,
	input  logic [MM_DATA_W-1:0]   sel_mm_readdata,

	// standard controller windows
	output logic                   std0_mm_read,
	output logic                   std0_mm_write,
	output logic [OFS_STD_W-1:0]   std0_mm_address,
	output logic [MM_DATA_W-1:0]   std0_mm_writedata,
	input  logic [MM_DATA_W-1:0]   std0_mm_readdata,
	input  logic                   std0_mm_waitrequest,
	output logic                   std1_mm_read,
	output logic                   std1_mm_write,
	output logic [OFS_STD_W-1:0]   std1_mm_address,
	output logic [MM_DATA_W-1:0]   std1_mm_writedata,
	input  logic [MM_DATA_W-1:0]   std1_mm_readdata,
	input  logic                   std1_mm_waitrequest
);

	logic [1:0] region;
	logic       hit_ptp;
	logic       hit_sel;
	logic       hit_std0;
	logic       hit_std1;

	assign region   = avl_mm_baddress[HOST_ADDR_W-1:REGION_LSB];
	assign hit_ptp  = (region == REGION_1588);
	assign hit_sel  = (region == REGION_SEL);
	assign hit_std0 = (region == REGION_STD0);
	assign hit_std1 = (region == REGION_STD3);

	// strobes only reach the addressed window
	assign ptp_mm_read   = avl_mm_read  & hit_ptp;
	assign ptp_mm_write  = avl_mm_write & hit_ptp;
	assign sel_mm_read   = avl_mm_read  & hit_sel;
	assign sel_mm_write  = avl_mm_write & hit_sel;
	assign std0_mm_read  = avl_mm_read  & hit_std0;
	assign std0_mm_write = avl_mm_write & hit_std0;
	assign std1_mm_read  = avl_mm_read  & hit_std1;
	assign std1_mm_write = avl_mm_write & hit_std1;

	// offsets and write data fan out to every window
	assign ptp_mm_address    = avl_mm_baddress[OFS_1588_W-1:0];
	assign sel_mm_address    = avl_mm_baddress[0];
	assign std0_mm_address   = avl_mm_baddress[OFS_STD_W-1:0];
	assign std1_mm_address   = avl_mm_baddress[OFS_STD_W-1:0];
	assign ptp_mm_writedata  = avl_mm_writedata;
	assign sel_mm_writedata  = avl_mm_writedata;
	assign std0_mm_writedata = avl_mm_writedata;
	assign std1_mm_writedata = avl_mm_writedata;

	// return path from the same region
	always_comb
	begin
		case (region)
			REGION_1588:
			begin
				avl_mm_readdata    = ptp_mm_readdata;
				avl_mm_waitrequest = ptp_mm_waitrequest;
			end
			REGION_SEL:
			begin
				avl_mm_readdata    = sel_mm_readdata;
				avl_mm_waitrequest = 1'b0;
			end
			REGION_STD0:
			begin
				avl_mm_readdata    = std0_mm_readdata;
				avl_mm_waitrequest = std0_mm_waitrequest;
			end
			default:
			begin
				avl_mm_readdata    = std1_mm_readdata;
				avl_mm_waitrequest = std1_mm_waitrequest;
			end
		endcase
	end

endmodule

// ==== rtl/eth_tc_sel_csr.sv ====
// select applies to both channels at once; only bit 0 of a control write is stored
`timescale 1ns/1ps

module eth_tc_sel_csr
	import eth_tc_map_pkg::*;
	import eth_tc_stream_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	// selector window, zero wait
	input  logic                    read,
	input  logic                    write,
	input  logic                    address,
	input  logic [MM_DATA_W-1:0]    writedata,
	output logic [MM_DATA_W-1:0]    readdata,

	// per-channel state back from the path muxes
	input  logic [NUM_CHANNELS-1:0] eff_sel,
	input  logic [NUM_CHANNELS-1:0] busy,
	output logic                    req_sel
);

	sel_word_u wr_word;
	sel_word_u ctrl_word;
	sel_word_u stat_word;
	logic      sel_q;

	assign wr_word = writedata;

	// requested source, 1588 after reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sel_q <= SRC_1588;
		else if (write && address == SEL_CTRL_OFS)
			sel_q <= wr_word.ctrl.sel;
	end

	assign req_sel = sel_q;

	// readback words, reserved bits read as zero
	always_comb
	begin
		ctrl_word              = '0;
		ctrl_word.ctrl.sel     = sel_q;
		stat_word              = '0;
		stat_word.stat.eff_sel = eff_sel;
		stat_word.stat.busy    = busy;
	end

	assign readdata = (address == SEL_STAT_OFS) ? stat_word : ctrl_word;

	// decoder hands us one access per cycle
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
		else $error("selector read and write in the same cycle");

endmodule

// ==== rtl/avl_st_path_mux.sv ====
// one channel; a selection change waits for any open tx or rx packet, nothing is buffered
`timescale 1ns/1ps

module avl_st_path_mux
	import eth_tc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   req_sel,
	output logic                   eff_sel,
	output logic                   busy,

	// transmit sources
	input  logic [ST_DATA_W-1:0]   ptp_tx_data,
	input  logic [ST_EMPTY_W-1:0]  ptp_tx_empty,
	input  logic                   ptp_tx_sop, ptp_tx_eop, ptp_tx_error, ptp_tx_val,
	output logic                   ptp_tx_ready,
	input  logic [ST_DATA_W-1:0]   std_tx_data,
	input  logic [ST_EMPTY_W-1:0]  std_tx_empty,
	input  logic                   std_tx_sop, std_tx_eop, std_tx_error, std_tx_val,
	output logic                   std_tx_ready,

	// transmit to MAC
	output logic [ST_DATA_W-1:0]   mac_tx_data,
	output logic [ST_EMPTY_W-1:0]  mac_tx_empty,
	output logic                   mac_tx_sop, mac_tx_eop, mac_tx_error, mac_tx_val,
	input  logic                   mac_tx_ready,

	// receive from MAC
	input  logic [ST_DATA_W-1:0]   mac_rx_data,
	input  logic [ST_EMPTY_W-1:0]  mac_rx_empty,
	input  logic [ST_RX_ERR_W-1:0] mac_rx_error,
	input  logic                   mac_rx_sop, mac_rx_eop, mac_rx_val,
	output logic                   mac_rx_ready,

	// receive sinks
	output logic [ST_DATA_W-1:0]   ptp_rx_data,
	output logic [ST_EMPTY_W-1:0]  ptp_rx_empty,
	output logic [ST_RX_ERR_W-1:0] ptp_rx_error,
	output logic                   ptp_rx_sop, ptp_rx_eop, ptp_rx_val,
	input  logic                   ptp_rx_ready,
	output logic [ST_DATA_W-1:0]   std_rx_data,
	output logic [ST_EMPTY_W-1:0]  std_rx_empty,
	output logic [ST_RX_ERR_W-1:0] std_rx_error,
	output logic                   std_rx_sop, std_rx_eop, std_rx_val,
	input  logic                   std_rx_ready
);

	logic sel_std;
	logic tx_open;
	logic tx_close;
	logic rx_open;
	logic rx_close;
	logic tx_busy;
	logic rx_busy;

	assign sel_std = (eff_sel == SRC_STD);

	//////////////////////////////////////////////////////////////////////
	// transmit mux
	//////////////////////////////////////////////////////////////////////

	assign mac_tx_data  = sel_std ? std_tx_data  : ptp_tx_data;
	assign mac_tx_empty = sel_std ? std_tx_empty : ptp_tx_empty;
	assign mac_tx_sop   = sel_std ? std_tx_sop   : ptp_tx_sop;
	assign mac_tx_eop   = sel_std ? std_tx_eop   : ptp_tx_eop;
	assign mac_tx_error = sel_std ? std_tx_error : ptp_tx_error;
	assign mac_tx_val   = sel_std ? std_tx_val   : ptp_tx_val;

	// unselected source is held off
	assign ptp_tx_ready = mac_tx_ready & ~sel_std;
	assign std_tx_ready = mac_tx_ready & sel_std;

	//////////////////////////////////////////////////////////////////////
	// receive demux
	//////////////////////////////////////////////////////////////////////

	// payload goes to both sinks, only valid is steered
	assign ptp_rx_data  = mac_rx_data;
	assign ptp_rx_empty = mac_rx_empty;
	assign ptp_rx_error = mac_rx_error;
	assign ptp_rx_sop   = mac_rx_sop;
	assign ptp_rx_eop   = mac_rx_eop;
	assign ptp_rx_val   = mac_rx_val & ~sel_std;
	assign std_rx_data  = mac_rx_data;
	assign std_rx_empty = mac_rx_empty;
	assign std_rx_error = mac_rx_error;
	assign std_rx_sop   = mac_rx_sop;
	assign std_rx_eop   = mac_rx_eop;
	assign std_rx_val   = mac_rx_val & sel_std;

	assign mac_rx_ready = sel_std ? std_rx_ready : ptp_rx_ready;

	//////////////////////////////////////////////////////////////////////
	// packet guard
	//////////////////////////////////////////////////////////////////////

	// beats as seen on the MAC side
	assign tx_open  = mac_tx_val & mac_tx_ready & mac_tx_sop & ~mac_tx_eop;
	assign tx_close = mac_tx_val & mac_tx_ready & mac_tx_eop;
	assign rx_open  = mac_rx_val & mac_rx_ready & mac_rx_sop & ~mac_rx_eop;
	assign rx_close = mac_rx_val & mac_rx_ready & mac_rx_eop;

	// each direction tracks its own packet
	assign busy = tx_busy | rx_busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_busy <= 1'b0;
			rx_busy <= 1'b0;
			eff_sel <= SRC_1588;
		end
		else
		begin
			if (tx_open)
				tx_busy <= 1'b1;
			else if (tx_close)
				tx_busy <= 1'b0;
			if (rx_open)
				rx_busy <= 1'b1;
			else if (rx_close)
				rx_busy <= 1'b0;
			// switch only between packets
			if (!busy && !tx_open && !rx_open)
				eff_sel <= req_sel;
		end
	end

endmodule

// ==== rtl/eth_traffic_router_top.sv ====
// traffic controllers sit outside; their MM windows and streams are ports of this level
`timescale 1ns/1ps

module eth_traffic_router_top
	import eth_tc_map_pkg::*;
	import eth_tc_stream_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	// host
	input  logic                   avl_mm_read,
	input  logic                   avl_mm_write,
	input  logic [HOST_ADDR_W-1:0] avl_mm_baddress,
	input  logic [MM_DATA_W-1:0]   avl_mm_writedata,
	output logic [MM_DATA_W-1:0]   avl_mm_readdata,
	output logic                   avl_mm_waitrequest,

	// controller windows
	output logic                   ptp_mm_read,
	output logic                   ptp_mm_write,
	output logic [OFS_1588_W-1:0]  ptp_mm_address,
	output logic [MM_DATA_W-1:0]   ptp_mm_writedata,
	input  logic [MM_DATA_W-1:0]   ptp_mm_readdata,
	input  logic                   ptp_mm_waitrequest,
	output logic                   std0_mm_read,
	output logic                   std0_mm_write,
	output logic [OFS_STD_W-1:0]   std0_mm_address,
	output logic [MM_DATA_W-1:0]   std0_mm_writedata,
	input  logic [MM_DATA_W-1:0]   std0_mm_readdata,
	input  logic                   std0_mm_waitrequest,
	output logic                   std1_mm_read,
	output logic                   std1_mm_write,
	output logic [OFS_STD_W-1:0]   std1_mm_address,
	output logic [MM_DATA_W-1:0]   std1_mm_writedata,
	input  logic [MM_DATA_W-1:0]   std1_mm_readdata,
	input  logic                   std1_mm_waitrequest,

	// transmit sources
	input  logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]  ptp_tx_data,
	input  logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0] ptp_tx_empty,
	input  logic [NUM_CHANNELS-1:0] ptp_tx_sop, ptp_tx_eop, ptp_tx_error, ptp_tx_val,
	output logic [NUM_CHANNELS-1:0] ptp_tx_ready,
	input  logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]  std_tx_data,
	input  logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0] std_tx_empty,
	input  logic [NUM_CHANNELS-1:0] std_tx_sop, std_tx_eop, std_tx_error, std_tx_val,
	output logic [NUM_CHANNELS-1:0] std_tx_ready,

	// MAC transmit and receive
	output logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]  mac_tx_data,
	output logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0] mac_tx_empty,
	output logic [NUM_CHANNELS-1:0] mac_tx_sop, mac_tx_eop, mac_tx_error, mac_tx_val,
	input  logic [NUM_CHANNELS-1:0] mac_tx_ready,
	input  logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]   mac_rx_data,
	input  logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0]  mac_rx_empty,
	input  logic [NUM_CHANNELS-1:0][ST_RX_ERR_W-1:0] mac_rx_error,
	input  logic [NUM_CHANNELS-1:0] mac_rx_sop, mac_rx_eop, mac_rx_val,
	output logic [NUM_CHANNELS-1:0] mac_rx_ready,

	// receive sinks
	output logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]   ptp_rx_data,
	output logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0]  ptp_rx_empty,
	output logic [NUM_CHANNELS-1:0][ST_RX_ERR_W-1:0] ptp_rx_error,
	output logic [NUM_CHANNELS-1:0] ptp_rx_sop, ptp_rx_eop, ptp_rx_val,
	input  logic [NUM_CHANNELS-1:0] ptp_rx_ready,
	output logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]   std_rx_data,
	output logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0]  std_rx_empty,
	output logic [NUM_CHANNELS-1:0][ST_RX_ERR_W-1:0] std_rx_error,
	output logic [NUM_CHANNELS-1:0] std_rx_sop, std_rx_eop, std_rx_val,
	input  logic [NUM_CHANNELS-1:0] std_rx_ready
);

	// selector window
	logic                    sel_mm_read;
	logic                    sel_mm_write;
	logic [0:0]              sel_mm_address;
	logic [MM_DATA_W-1:0]    sel_mm_writedata;
	logic [MM_DATA_W-1:0]    sel_mm_readdata;

	logic                    req_sel;
	logic [NUM_CHANNELS-1:0] eff_sel;
	logic [NUM_CHANNELS-1:0] busy;

	// port names match the decoder one to one
	eth_tc_addr_decoder u_addr_decoder (.*);

	eth_tc_sel_csr u_sel_csr (
		.clk       (clk),
		.rst_n     (rst_n),
		.read      (sel_mm_read),
		.write     (sel_mm_write),
		.address   (sel_mm_address[0]),
		.writedata (sel_mm_writedata),
		.readdata  (sel_mm_readdata),
		.eff_sel   (eff_sel),
		.busy      (busy),
		.req_sel   (req_sel)
	);

	//////////////////////////////////////////////////////////////////////
	// one path mux per MAC channel
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_path
		avl_st_path_mux u_path_mux (
			.clk          (clk),
			.rst_n        (rst_n),
			.req_sel      (req_sel),
			.eff_sel      (eff_sel[i]),
			.busy         (busy[i]),
			.ptp_tx_data  (ptp_tx_data[i]),
			.ptp_tx_empty (ptp_tx_empty[i]),
			.ptp_tx_sop   (ptp_tx_sop[i]),
			.ptp_tx_eop   (ptp_tx_eop[i]),
			.ptp_tx_error (ptp_tx_error[i]),
			.ptp_tx_val   (ptp_tx_val[i]),
			.ptp_tx_ready (ptp_tx_ready[i]),
			.std_tx_data  (std_tx_data[i]),
			.std_tx_empty (std_tx_empty[i]),
			.std_tx_sop   (std_tx_sop[i]),
			.std_tx_eop   (std_tx_eop[i]),
			.std_tx_error (std_tx_error[i]),
			.std_tx_val   (std_tx_val[i]),
			.std_tx_ready (std_tx_ready[i]),
			.mac_tx_data  (mac_tx_data[i]),
			.mac_tx_empty (mac_tx_empty[i]),
			.mac_tx_sop   (mac_tx_sop[i]),
			.mac_tx_eop   (mac_tx_eop[i]),
			.mac_tx_error (mac_tx_error[i]),
			.mac_tx_val   (mac_tx_val[i]),
			.mac_tx_ready (mac_tx_ready[i]),
			.mac_rx_data  (mac_rx_data[i]),
			.mac_rx_empty (mac_rx_empty[i]),
			.mac_rx_error (mac_rx_error[i]),
			.mac_rx_sop   (mac_rx_sop[i]),
			.mac_rx_eop   (mac_rx_eop[i]),
			.mac_rx_val   (mac_rx_val[i]),
			.mac_rx_ready (mac_rx_ready[i]),
			.ptp_rx_data  (ptp_rx_data[i]),
			.ptp_rx_empty (ptp_rx_empty[i]),
			.ptp_rx_error (ptp_rx_error[i]),
			.ptp_rx_sop   (ptp_rx_sop[i]),
			.ptp_rx_eop   (ptp_rx_eop[i]),
			.ptp_rx_val   (ptp_rx_val[i]),
			.ptp_rx_ready (ptp_rx_ready[i]),
			.std_rx_data  (std_rx_data[i]),
			.std_rx_empty (std_rx_empty[i]),
			.std_rx_error (std_rx_error[i]),
			.std_rx_sop   (std_rx_sop[i]),
			.std_rx_eop   (std_rx_eop[i]),
			.std_rx_val   (std_rx_val[i]),
			.std_rx_ready (std_rx_ready[i])
		);
	end

endmodule

// ==== verification/tb_clk_gen.sv ====
// free-running 8 ns clock; reset is released 1 ns after the third rising edge
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hold reset for three cycles
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== verification/tb_eth_traffic_router.sv ====
// directed tests only; inputs move 1 ns after the rising edge and outputs are sampled 2 ns later
`timescale 1ns/1ps

module tb_eth_traffic_router
	import eth_tc_map_pkg::*;
	import eth_tc_stream_pkg::*;
();

	localparam logic [HOST_ADDR_W-1:0] CTRL_ADDR = {REGION_SEL, 11'd0, SEL_CTRL_OFS};
	localparam logic [HOST_ADDR_W-1:0] STAT_ADDR = {REGION_SEL, 11'd0, SEL_STAT_OFS};
	localparam int WAIT_LIMIT = 16;

	logic clk;
	logic rst_n;

	logic                   avl_mm_read, avl_mm_write, avl_mm_waitrequest;
	logic [HOST_ADDR_W-1:0] avl_mm_baddress;
	logic [MM_DATA_W-1:0]   avl_mm_writedata, avl_mm_readdata;
	logic                   ptp_mm_read, ptp_mm_write, ptp_mm_waitrequest;
	logic [OFS_1588_W-1:0]  ptp_mm_address;
	logic [MM_DATA_W-1:0]   ptp_mm_writedata, ptp_mm_readdata;
	logic                   std0_mm_read, std0_mm_write, std0_mm_waitrequest;
	logic [OFS_STD_W-1:0]   std0_mm_address;
	logic [MM_DATA_W-1:0]   std0_mm_writedata, std0_mm_readdata;
	logic                   std1_mm_read, std1_mm_write, std1_mm_waitrequest;
	logic [OFS_STD_W-1:0]   std1_mm_address;
	logic [MM_DATA_W-1:0]   std1_mm_writedata, std1_mm_readdata;

	logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]   ptp_tx_data, std_tx_data, mac_tx_data;
	logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0]  ptp_tx_empty, std_tx_empty, mac_tx_empty;
	logic [NUM_CHANNELS-1:0] ptp_tx_sop, ptp_tx_eop, ptp_tx_error, ptp_tx_val, ptp_tx_ready;
	logic [NUM_CHANNELS-1:0] std_tx_sop, std_tx_eop, std_tx_error, std_tx_val, std_tx_ready;
	logic [NUM_CHANNELS-1:0] mac_tx_sop, mac_tx_eop, mac_tx_error, mac_tx_val, mac_tx_ready;
	logic [NUM_CHANNELS-1:0][ST_DATA_W-1:0]   mac_rx_data, ptp_rx_data, std_rx_data;
	logic [NUM_CHANNELS-1:0][ST_EMPTY_W-1:0]  mac_rx_empty, ptp_rx_empty, std_rx_empty;
	logic [NUM_CHANNELS-1:0][ST_RX_ERR_W-1:0] mac_rx_error, ptp_rx_error, std_rx_error;
	logic [NUM_CHANNELS-1:0] mac_rx_sop, mac_rx_eop, mac_rx_val, mac_rx_ready;
	logic [NUM_CHANNELS-1:0] ptp_rx_sop, ptp_rx_eop, ptp_rx_val, ptp_rx_ready;
	logic [NUM_CHANNELS-1:0] std_rx_sop, std_rx_eop, std_rx_val, std_rx_ready;

	logic [31:0] lfsr;
	int          errors;
	int          timeouts;

	tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	eth_traffic_router_top uut (.*);

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic init_inputs();
		avl_mm_read = 1'b0;
		avl_mm_write = 1'b0;
		avl_mm_baddress = '0;
		avl_mm_writedata = '0;
		ptp_mm_readdata = '0;
		ptp_mm_waitrequest = 1'b0;
		std0_mm_readdata = '0;
		std0_mm_waitrequest = 1'b0;
		std1_mm_readdata = '0;
		std1_mm_waitrequest = 1'b0;
		ptp_tx_data = '0;
		ptp_tx_empty = '0;
		ptp_tx_sop = '0;
		ptp_tx_eop = '0;
		ptp_tx_error = '0;
		ptp_tx_val = '0;
		std_tx_data = '0;
		std_tx_empty = '0;
		std_tx_sop = '0;
		std_tx_eop = '0;
		std_tx_error = '0;
		std_tx_val = '0;
		mac_tx_ready = '1;
		mac_rx_data = '0;
		mac_rx_empty = '0;
		mac_rx_error = '0;
		mac_rx_sop = '0;
		mac_rx_eop = '0;
		mac_rx_val = '0;
		ptp_rx_ready = '1;
		std_rx_ready = '1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_mm_data(input logic [MM_DATA_W-1:0] got,
			input logic [MM_DATA_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_st_data(input logic [ST_DATA_W-1:0] got,
			input logic [ST_DATA_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_st_empty(input logic [ST_EMPTY_W-1:0] got,
			input logic [ST_EMPTY_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_rx_error(input logic [ST_RX_ERR_W-1:0] got,
			input logic [ST_RX_ERR_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_sel_word(input sel_word_u got, input sel_word_u exp,
			input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// host access, held until waitrequest drops
	//////////////////////////////////////////////////////////////////////

	task automatic mm_access(input logic wr, input logic [HOST_ADDR_W-1:0] addr,
			input logic [MM_DATA_W-1:0] wdata, output logic [MM_DATA_W-1:0] rdata);
		int n;
		n = 0;
		avl_mm_baddress = addr;
		avl_mm_writedata = wdata;
		avl_mm_read = ~wr;
		avl_mm_write = wr;
		#2;
		while (avl_mm_waitrequest && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#3;
			n++;
		end
		if (avl_mm_waitrequest)
		begin
			timeouts++;
			$display("timeout: host access to %h was never accepted", addr);
		end
		rdata = avl_mm_readdata;
		next_cycle();
		avl_mm_read = 1'b0;
		avl_mm_write = 1'b0;
	endtask

	// poll status until both effective selections match
	task automatic wait_status(input logic [1:0] eff_exp, input logic [1:0] busy_exp,
			input string what);
		sel_word_u got;
		sel_word_u exp;
		int        n;
		exp = '0;
		exp.stat.eff_sel = eff_exp;
		exp.stat.busy = busy_exp;
		n = 0;
		mm_access(1'b0, STAT_ADDR, '0, got);
		while (got.stat.eff_sel !== eff_exp && n < WAIT_LIMIT)
		begin
			mm_access(1'b0, STAT_ADDR, '0, got);
			n++;
		end
		if (got.stat.eff_sel !== eff_exp)
		begin
			timeouts++;
			$display("timeout: effective selection never reached %b (%s)", eff_exp, what);
		end
		compare_sel_word(got, exp, what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_routing();
		logic [63:0] v;
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			rand_bits(ST_DATA_W, v);
			ptp_tx_data[c] = v;
			rand_bits(ST_DATA_W, v);
			std_tx_data[c] = v;
			rand_bits(ST_DATA_W, v);
			mac_rx_data[c] = v;
			rand_bits(ST_EMPTY_W, v);
			ptp_tx_empty[c] = v[ST_EMPTY_W-1:0];
			std_tx_empty[c] = ~v[ST_EMPTY_W-1:0];
			rand_bits(ST_EMPTY_W, v);
			mac_rx_empty[c] = v[ST_EMPTY_W-1:0];
			rand_bits(ST_RX_ERR_W, v);
			mac_rx_error[c] = v[ST_RX_ERR_W-1:0];
			// single-beat packets, so the guard stays idle
			ptp_tx_sop[c] = 1'b1;
			ptp_tx_eop[c] = 1'b1;
			ptp_tx_error[c] = 1'b1;
			mac_rx_sop[c] = 1'b1;
			mac_rx_eop[c] = 1'b1;
			ptp_tx_val[c] = 1'b1;
			mac_rx_val[c] = 1'b1;
			#2;
			compare_st_data(mac_tx_data[c], ptp_tx_data[c], "reset: mac tx data");
			compare_st_empty(mac_tx_empty[c], ptp_tx_empty[c], "reset: mac tx empty");
			compare_bit(mac_tx_sop[c], 1'b1, "reset: mac tx sop");
			compare_bit(mac_tx_eop[c], 1'b1, "reset: mac tx eop");
			compare_bit(mac_tx_error[c], 1'b1, "reset: mac tx error");
			compare_bit(mac_tx_val[c], 1'b1, "reset: mac tx valid");
			compare_bit(ptp_tx_ready[c], 1'b1, "reset: ptp tx ready");
			compare_bit(std_tx_ready[c], 1'b0, "reset: std tx ready");
			compare_bit(ptp_rx_val[c], 1'b1, "reset: ptp rx valid");
			compare_bit(std_rx_val[c], 1'b0, "reset: std rx valid");
			compare_st_data(ptp_rx_data[c], mac_rx_data[c], "reset: ptp rx data");
			compare_st_empty(ptp_rx_empty[c], mac_rx_empty[c], "reset: ptp rx empty");
			compare_rx_error(ptp_rx_error[c], mac_rx_error[c], "reset: ptp rx error");
			compare_bit(ptp_rx_sop[c], 1'b1, "reset: ptp rx sop");
			compare_bit(ptp_rx_eop[c], 1'b1, "reset: ptp rx eop");
			next_cycle();
			ptp_tx_sop[c] = 1'b0;
			ptp_tx_eop[c] = 1'b0;
			ptp_tx_error[c] = 1'b0;
			mac_rx_sop[c] = 1'b0;
			mac_rx_eop[c] = 1'b0;
			ptp_tx_val[c] = 1'b0;
			mac_rx_val[c] = 1'b0;
		end
	endtask

	task automatic test_address_routing();
		logic [1:0]          r;
		logic [63:0]         v;
		logic [MM_DATA_W-1:0] exp_rd;
		for (int k = 0; k < 3; k++)
		begin
			r = (k == 0) ? REGION_1588 : 2'(k + 1);
			rand_bits(OFS_STD_W, v);
			avl_mm_baddress = {r, v[OFS_STD_W-1:0]};
			rand_bits(MM_DATA_W, v);
			avl_mm_writedata = v[MM_DATA_W-1:0];
			rand_bits(MM_DATA_W, v);
			ptp_mm_readdata = v[MM_DATA_W-1:0];
			rand_bits(MM_DATA_W, v);
			std0_mm_readdata = v[MM_DATA_W-1:0];
			rand_bits(MM_DATA_W, v);
			std1_mm_readdata = v[MM_DATA_W-1:0];
			exp_rd = (r == REGION_1588) ? ptp_mm_readdata :
				(r == REGION_STD0) ? std0_mm_readdata : std1_mm_readdata;
			ptp_mm_waitrequest = (r == REGION_1588);
			std0_mm_waitrequest = (r == REGION_STD0);
			std1_mm_waitrequest = (r == REGION_STD3);
			avl_mm_write = 1'b1;
			#2;
			compare_bit(ptp_mm_write, r == REGION_1588, "route: ptp write strobe");
			compare_bit(std0_mm_write, r == REGION_STD0, "route: std0 write strobe");
			compare_bit(std1_mm_write, r == REGION_STD3, "route: std1 write strobe");
			compare_bit(ptp_mm_read | std0_mm_read | std1_mm_read, 1'b0, "route: read strobes");
			compare_mm_data(avl_mm_readdata, exp_rd, "route: host readdata");
			compare_bit(avl_mm_waitrequest, 1'b1, "route: host waitrequest high");
			if (r == REGION_1588)
			begin
				compare_mm_data(ptp_mm_address, avl_mm_baddress[OFS_1588_W-1:0],
					"route: ptp offset");
				compare_mm_data(ptp_mm_writedata, avl_mm_writedata, "route: ptp writedata");
			end
			else
			begin
				compare_mm_data(std0_mm_address, avl_mm_baddress[OFS_STD_W-1:0],
					"route: std0 offset");
				compare_mm_data(std1_mm_address, avl_mm_baddress[OFS_STD_W-1:0],
					"route: std1 offset");
				compare_mm_data(std0_mm_writedata, avl_mm_writedata, "route: std0 writedata");
				compare_mm_data(std1_mm_writedata, avl_mm_writedata, "route: std writedata");
			end
			next_cycle();
			// release the window's wait, then swap to a read
			ptp_mm_waitrequest = 1'b0;
			std0_mm_waitrequest = 1'b0;
			std1_mm_waitrequest = 1'b0;
			avl_mm_write = 1'b0;
			avl_mm_read = 1'b1;
			#2;
			compare_bit(avl_mm_waitrequest, 1'b0, "route: host waitrequest low");
			compare_bit(ptp_mm_read, r == REGION_1588, "route: ptp read strobe");
			compare_bit(std0_mm_read, r == REGION_STD0, "route: std0 read strobe");
			compare_bit(std1_mm_read, r == REGION_STD3, "route: std1 read strobe");
			next_cycle();
			avl_mm_read = 1'b0;
		end
	endtask

	task automatic test_selector_register();
		sel_word_u wr;
		sel_word_u got;
		sel_word_u exp;
		wr = '0;
		wr.ctrl.sel = SRC_STD;
		mm_access(1'b1, CTRL_ADDR, wr, got);
		mm_access(1'b0, CTRL_ADDR, '0, got);
		exp = '0;
		exp.ctrl.sel = 1'b1;
		compare_sel_word(got, exp, "selector: ctrl readback");
		wait_status(2'b11, 2'b00, "selector: both channels standard");
	endtask

	task automatic test_packet_guard();
		logic [MM_DATA_W-1:0] rd;
		mm_access(1'b1, CTRL_ADDR, 32'h0, rd);
		wait_status(2'b00, 2'b00, "guard: both channels back on 1588");
		// open a 1588 packet on channel 0
		ptp_tx_sop[0] = 1'b1;
		ptp_tx_val[0] = 1'b1;
		next_cycle();
		ptp_tx_sop[0] = 1'b0;
		ptp_tx_val[0] = 1'b0;
		mm_access(1'b1, CTRL_ADDR, 32'h1, rd);
		wait_status(2'b10, 2'b01, "guard: channel 0 held, channel 1 switched");
		ptp_tx_eop[0] = 1'b1;
		ptp_tx_val[0] = 1'b1;
		next_cycle();
		ptp_tx_eop[0] = 1'b0;
		ptp_tx_val[0] = 1'b0;
		wait_status(2'b11, 2'b00, "guard: channel 0 switched after eop");
	endtask

	task automatic test_rx_demux_backpressure();
		logic [63:0] v;
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			rand_bits(ST_DATA_W, v);
			mac_rx_data[c] = v;
			rand_bits(ST_DATA_W, v);
			std_tx_data[c] = v;
			std_tx_sop[c] = 1'b1;
			std_tx_eop[c] = 1'b1;
			std_tx_error[c] = 1'b1;
			mac_rx_sop[c] = 1'b1;
			mac_rx_eop[c] = 1'b1;
			mac_rx_val[c] = 1'b1;
			std_tx_val[c] = 1'b1;
			#2;
			compare_bit(std_rx_val[c], 1'b1, "demux: std rx valid");
			compare_bit(ptp_rx_val[c], 1'b0, "demux: ptp rx valid");
			compare_st_data(std_rx_data[c], mac_rx_data[c], "demux: std rx data");
			compare_st_empty(std_rx_empty[c], mac_rx_empty[c], "demux: std rx empty");
			compare_rx_error(std_rx_error[c], mac_rx_error[c], "demux: std rx error");
			compare_bit(std_rx_sop[c], 1'b1, "demux: std rx sop");
			compare_bit(std_rx_eop[c], 1'b1, "demux: std rx eop");
			compare_st_data(ptp_rx_data[c], mac_rx_data[c], "demux: ptp rx data");
			compare_st_data(mac_tx_data[c], std_tx_data[c], "demux: mac tx data");
			compare_st_empty(mac_tx_empty[c], std_tx_empty[c], "demux: mac tx empty");
			compare_bit(mac_tx_sop[c], 1'b1, "demux: mac tx sop");
			compare_bit(mac_tx_eop[c], 1'b1, "demux: mac tx eop");
			compare_bit(mac_tx_error[c], 1'b1, "demux: mac tx error");
			compare_bit(mac_rx_ready[c], 1'b1, "demux: mac rx ready");
			// single-beat packets transfer on this edge
			next_cycle();
			std_rx_ready[c] = 1'b0;
			mac_tx_ready[c] = 1'b0;
			#2;
			compare_bit(mac_rx_ready[c], 1'b0, "backpressure: mac rx ready");
			compare_bit(std_tx_ready[c], 1'b0, "backpressure: std tx ready");
			compare_bit(ptp_tx_ready[c], 1'b0, "backpressure: ptp tx ready");
			next_cycle();
			std_rx_ready[c] = 1'b1;
			mac_tx_ready[c] = 1'b1;
			mac_rx_val[c] = 1'b0;
			std_tx_val[c] = 1'b0;
			std_tx_sop[c] = 1'b0;
			std_tx_eop[c] = 1'b0;
			std_tx_error[c] = 1'b0;
			mac_rx_sop[c] = 1'b0;
			mac_rx_eop[c] = 1'b0;
			#2;
			compare_bit(std_tx_ready[c], 1'b1, "backpressure: std tx ready restored");
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int n;
		errors = 0;
		timeouts = 0;
		lfsr = 32'h377a_3eee;
		init_inputs();
		n = 0;
		while (rst_n !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
		begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		next_cycle();
		test_reset_routing();
		test_address_routing();
		test_selector_register();
		test_packet_guard();
		test_rx_demux_backpressure();
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/eth_tc_map_pkg.sv
rtl/eth_tc_stream_pkg.sv
rtl/eth_tc_addr_decoder.sv
rtl/eth_tc_sel_csr.sv
rtl/avl_st_path_mux.sv
rtl/eth_traffic_router_top.sv
verification/tb_clk_gen.sv
verification/tb_eth_traffic_router.sv
